// File: hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

   // host byte address
   typedef logic [15:0] addr_t;

   // host data word, also used on the internal byte lanes
   typedef logic [31:0] word_t;

   // one enable bit per byte lane
   typedef logic [3:0]  be_t;

   // access size as seen on the host port
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,  // 8 bit
      SIZE_HALF = 2'd1,  // 16 bit, must be 2-byte aligned
      SIZE_WORD = 2'd2   // 32 bit, must be 4-byte aligned
   } size_e;

   // address map
   // data memory starts at 0x0000, its size is set by MEM_ADDR_WIDTH
   localparam addr_t IO_BASE = 16'h8000;   // start of register window

   // register window is 16 bytes, 4 words
   localparam int unsigned IO_WINDOW_BITS = 4;

   // register bank word offsets
   localparam logic [1:0] IO_OFS_SCRATCH = 2'd0;
   localparam logic [1:0] IO_OFS_LED     = 2'd1;
   localparam logic [1:0] IO_OFS_CYCLES  = 2'd2;
   localparam logic [1:0] IO_OFS_ID      = 2'd3;

   // value returned at IO_BASE + 0xC
   localparam word_t ID_VALUE = 32'h4D53_0001;

endpackage

`default_nettype wire

// File: hw/bus_req_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_req_ctrl (
   input  logic                clk_i,
   input  logic                reset_i,
   // host request, held stable by the host while req_i is high
   input  logic                req_i,
   input  logic                we_i,
   input  mem_bus_pkg::size_e  size_i,
   input  logic                signed_i,
   input  mem_bus_pkg::addr_t  addr_i,
   input  mem_bus_pkg::word_t  wdata_i,
   // result of the access, valid while access_o is high
   input  mem_bus_pkg::word_t  load_data_i,
   input  logic                err_i,
   // registered request toward the datapath
   output logic                access_o,
   output logic                we_o,
   output mem_bus_pkg::size_e  size_o,
   output logic                signed_o,
   output mem_bus_pkg::addr_t  addr_o,
   output mem_bus_pkg::word_t  wdata_o,
   // host response
   output logic                ack_o,
   output mem_bus_pkg::word_t  rdata_o,
   output logic                err_o
);

   typedef enum logic [1:0] {
      ST_IDLE,    // waiting for req_i
      ST_ACCESS,  // one cycle, datapath works on the latched request
      ST_ACK      // result held, ack_o raised one cycle later, wait for req_i low
   } state_e;

   state_e state_q;

   assign access_o = (state_q == ST_ACCESS);

   // control state
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
         ack_o   <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               ack_o <= 1'b0;
               if (req_i) state_q <= ST_ACCESS;  // fields latched below
            end
            ST_ACCESS: begin
               err_o   <= err_i;
               state_q <= ST_ACK;
            end
            ST_ACK: begin
               ack_o <= req_i;                   // rises 2 edges after req seen, falls with req
               if (!req_i) state_q <= ST_IDLE;
            end
            default: begin
               ack_o   <= 1'b0;
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // request fields and result word
   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && req_i) begin
         we_o     <= we_i;
         size_o   <= size_i;
         signed_o <= signed_i;
         addr_o   <= addr_i;
         wdata_o  <= wdata_i;
      end
      if (state_q == ST_ACCESS) begin
         // stores and failed accesses report zero
         rdata_o <= (we_o || err_i) ? '0 : load_data_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align (
   input  mem_bus_pkg::size_e  size_i,
   input  logic                signed_i,     // sign-extend loads
   input  mem_bus_pkg::addr_t  addr_i,
   input  mem_bus_pkg::word_t  wdata_i,      // store data, right-justified
   input  mem_bus_pkg::word_t  rdata_raw_i,  // raw word from the selected region
   output mem_bus_pkg::word_t  lane_wdata_o, // store data placed on its lanes
   output mem_bus_pkg::be_t    be_o,
   output logic                misaligned_o,
   output mem_bus_pkg::word_t  load_data_o   // extracted and extended load
);

   logic [1:0]          byte_ofs;
   mem_bus_pkg::word_t  shifted;
   logic [7:0]          load_byte;
   logic [15:0]         load_half;

   assign byte_ofs = addr_i[1:0];

   // alignment check
   always_comb begin
      case (size_i)
         mem_bus_pkg::SIZE_BYTE: misaligned_o = 1'b0;
         mem_bus_pkg::SIZE_HALF: misaligned_o = byte_ofs[0];
         mem_bus_pkg::SIZE_WORD: misaligned_o = (byte_ofs != 2'b00);
         default:                misaligned_o = 1'b1;  // reserved size code is an error
      endcase
   end

   // store side
   // data is replicated so every possible lane carries it, the mask picks the lane
   always_comb begin
      case (size_i)
         mem_bus_pkg::SIZE_BYTE: begin
            lane_wdata_o = {4{wdata_i[7:0]}};
            be_o         = 4'b0001 << byte_ofs;
         end
         mem_bus_pkg::SIZE_HALF: begin
            lane_wdata_o = {2{wdata_i[15:0]}};
            be_o         = byte_ofs[1] ? 4'b1100 : 4'b0011;
         end
         mem_bus_pkg::SIZE_WORD: begin
            lane_wdata_o = wdata_i;
            be_o         = 4'b1111;
         end
         default: begin
            lane_wdata_o = wdata_i;
            be_o         = 4'b0000;  // never written, flagged misaligned anyway
         end
      endcase
   end

   // load side
   assign shifted   = rdata_raw_i >> {byte_ofs, 3'b000};  // addressed byte to lane 0
   assign load_byte = shifted[7:0];
   assign load_half = byte_ofs[1] ? rdata_raw_i[31:16] : rdata_raw_i[15:0];

   always_comb begin
      case (size_i)
         mem_bus_pkg::SIZE_BYTE: begin
            load_data_o = {{24{signed_i & load_byte[7]}}, load_byte};
         end
         mem_bus_pkg::SIZE_HALF: begin
            load_data_o = {{16{signed_i & load_half[15]}}, load_half};
         end
         default: begin
            load_data_o = rdata_raw_i;  // word, nothing to extend
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode #(
   parameter int unsigned MEM_ADDR_WIDTH = 13  // byte address bits of data memory
) (
   input  logic                access_i,     // access cycle strobe
   input  logic                we_i,
   input  logic                misaligned_i,
   input  mem_bus_pkg::addr_t  addr_i,
   input  mem_bus_pkg::word_t  mem_rdata_i,
   input  mem_bus_pkg::word_t  io_rdata_i,
   output logic                mem_we_o,
   output logic                io_we_o,
   output logic                unmapped_o,
   output mem_bus_pkg::word_t  rdata_raw_o
);

   localparam int unsigned ADDR_W = $bits(mem_bus_pkg::addr_t);
   localparam int unsigned IO_W   = mem_bus_pkg::IO_WINDOW_BITS;

   logic mem_sel;
   logic io_sel;
   logic wr_ok;

   // memory sits at the bottom of the map, all upper bits zero
   assign mem_sel = (addr_i[ADDR_W-1:MEM_ADDR_WIDTH] == '0);
   assign io_sel  = (addr_i[ADDR_W-1:IO_W] == mem_bus_pkg::IO_BASE[ADDR_W-1:IO_W]);

   assign unmapped_o = !mem_sel && !io_sel;

   // only an aligned, mapped write during the access cycle reaches a region
   assign wr_ok    = access_i && we_i && !misaligned_i && !unmapped_o;
   assign mem_we_o = wr_ok && mem_sel;
   assign io_we_o  = wr_ok && io_sel;

   // read return, unmapped gives zero
   always_comb begin
      if (mem_sel)     rdata_raw_o = mem_rdata_i;
      else if (io_sel) rdata_raw_o = io_rdata_i;
      else             rdata_raw_o = '0;
   end

endmodule

`default_nettype wire

// File: hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
   parameter int unsigned MEM_ADDR_WIDTH = 13  // 2**MEM_ADDR_WIDTH bytes
) (
   input  logic                       clk_i,
   input  logic                       write_i,
   input  mem_bus_pkg::be_t           be_sel_i,
   input  logic [MEM_ADDR_WIDTH-1:0]  addr_i,  // byte address, low 2 bits ignored
   input  mem_bus_pkg::word_t         data_i,
   output mem_bus_pkg::word_t         data_o
);

   localparam int unsigned DEPTH = 2 ** MEM_ADDR_WIDTH;

   logic [7:0]                 mem [0:DEPTH-1];  // byte array, lane n at word base + n
   logic [MEM_ADDR_WIDTH-3:0]  word_addr;

   assign word_addr = addr_i[MEM_ADDR_WIDTH-1:2];

   // combinational read, one byte per lane
   for (genvar g = 0; g < 4; g++) begin : g_rd_lane
      assign data_o[8*g +: 8] = mem[{word_addr, 2'(g)}];
   end

   // byte-enabled write
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < 4; b++) begin
         if (write_i && be_sel_i[b]) begin
            mem[{word_addr, 2'(b)}] <= data_i[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                write_i,   // decoded write strobe
   input  mem_bus_pkg::be_t    be_sel_i,
   input  logic [1:0]          offset_i,  // word offset in the window
   input  mem_bus_pkg::word_t  data_i,
   output mem_bus_pkg::word_t  data_o,
   output logic [7:0]          led_o
);

   mem_bus_pkg::word_t  scratch_q;
   logic [7:0]          led_q;
   mem_bus_pkg::word_t  cycle_cnt_q;

   // scratch, written lane by lane
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         scratch_q <= '0;
      end else if (write_i && offset_i == mem_bus_pkg::IO_OFS_SCRATCH) begin
         for (int b = 0; b < 4; b++) begin
            if (be_sel_i[b]) scratch_q[8*b +: 8] <= data_i[8*b +: 8];
         end
      end
   end

   // led register, low lane only
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         led_q <= 8'h00;
      end else if (write_i && offset_i == mem_bus_pkg::IO_OFS_LED && be_sel_i[0]) begin
         led_q <= data_i[7:0];
      end
   end

   // free-running, wraps
   always_ff @(posedge clk_i) begin
      if (reset_i) cycle_cnt_q <= '0;
      else         cycle_cnt_q <= cycle_cnt_q + 32'd1;
   end

   assign led_o = led_q;

   // read mux, counter and id ignore writes
   always_comb begin
      case (offset_i)
         mem_bus_pkg::IO_OFS_SCRATCH: data_o = scratch_q;
         mem_bus_pkg::IO_OFS_LED:     data_o = {24'h0, led_q};
         mem_bus_pkg::IO_OFS_CYCLES:  data_o = cycle_cnt_q;
         default:                     data_o = mem_bus_pkg::ID_VALUE;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
   parameter int unsigned MEM_ADDR_WIDTH = 13  // 8 KiB data memory
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                req_i,
   input  logic                we_i,
   input  mem_bus_pkg::size_e  size_i,
   input  logic                signed_i,
   input  mem_bus_pkg::addr_t  addr_i,
   input  mem_bus_pkg::word_t  wdata_i,
   output logic                ack_o,
   output mem_bus_pkg::word_t  rdata_o,
   output logic                err_o,
   output logic [7:0]          led_o
);

   // latched request
   logic                access;
   logic                req_we;
   mem_bus_pkg::size_e  req_size;
   logic                req_signed;
   mem_bus_pkg::addr_t  req_addr;
   mem_bus_pkg::word_t  req_wdata;
   // datapath
   mem_bus_pkg::word_t  lane_wdata;
   mem_bus_pkg::be_t    be;
   logic                misaligned;
   logic                unmapped;
   logic                access_err;
   logic                mem_we;
   logic                io_we;
   mem_bus_pkg::word_t  mem_rdata;
   mem_bus_pkg::word_t  io_rdata;
   mem_bus_pkg::word_t  rdata_raw;
   mem_bus_pkg::word_t  load_data;

   assign access_err = misaligned | unmapped;  // either one fails the access

   bus_req_ctrl u_ctrl (
      .clk_i(clk_i), .reset_i(reset_i),
      .req_i(req_i), .we_i(we_i), .size_i(size_i), .signed_i(signed_i),
      .addr_i(addr_i), .wdata_i(wdata_i),
      .load_data_i(load_data), .err_i(access_err),
      .access_o(access), .we_o(req_we), .size_o(req_size), .signed_o(req_signed),
      .addr_o(req_addr), .wdata_o(req_wdata),
      .ack_o(ack_o), .rdata_o(rdata_o), .err_o(err_o)
   );

   lane_align u_align (
      .size_i(req_size), .signed_i(req_signed), .addr_i(req_addr),
      .wdata_i(req_wdata), .rdata_raw_i(rdata_raw),
      .lane_wdata_o(lane_wdata), .be_o(be), .misaligned_o(misaligned),
      .load_data_o(load_data)
   );

   addr_decode #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_decode (
      .access_i(access), .we_i(req_we), .misaligned_i(misaligned), .addr_i(req_addr),
      .mem_rdata_i(mem_rdata), .io_rdata_i(io_rdata),
      .mem_we_o(mem_we), .io_we_o(io_we), .unmapped_o(unmapped), .rdata_raw_o(rdata_raw)
   );

   data_mem #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_mem (
      .clk_i(clk_i), .write_i(mem_we), .be_sel_i(be),
      .addr_i(req_addr[MEM_ADDR_WIDTH-1:0]), .data_i(lane_wdata), .data_o(mem_rdata)
   );

   io_regs u_io (
      .clk_i(clk_i), .reset_i(reset_i), .write_i(io_we), .be_sel_i(be),
      .offset_i(req_addr[3:2]), .data_i(lane_wdata), .data_o(io_rdata), .led_o(led_o)
   );

endmodule

`default_nettype wire

// File: verif/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

   localparam int CLK_PERIOD     = 100;
   localparam int DRIVE_DLY      = 5;     // input change after the rising edge
   localparam int MEM_ADDR_WIDTH = 13;
   localparam int MEM_BYTES      = 2 ** MEM_ADDR_WIDTH;
   localparam int MEM_WORDS      = MEM_BYTES / 4;
   localparam int ACK_TIMEOUT    = 8;     // cycles before a handshake phase is given up
   localparam int N_WORDS        = 32;
   localparam int N_PART         = 24;
   localparam int N_LOAD         = 8;
   // word test uses 2 accesses per item, partial 3 and load 13 while io and error need about 45
   localparam int MAX_ACCESSES   = 2 * N_WORDS + 3 * N_PART + 13 * N_LOAD + 48;

   logic                clk;
   logic                reset;
   logic                req;
   logic                we;
   mem_bus_pkg::size_e  size;
   logic                sign_ld;
   mem_bus_pkg::addr_t  addr;
   mem_bus_pkg::word_t  wdata;
   logic                ack;
   mem_bus_pkg::word_t  rdata;
   logic                err;
   logic [7:0]          led;

   // reference state
   logic [7:0]          mem_model [int];  // only bytes that were written
   mem_bus_pkg::word_t  scratch_model;
   logic [7:0]          led_model;

   int tests;
   int checks;
   int errors;

   mem_subsystem_top #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_dut (
      .clk_i(clk), .reset_i(reset),
      .req_i(req), .we_i(we), .size_i(size), .signed_i(sign_ld),
      .addr_i(addr), .wdata_i(wdata),
      .ack_o(ack), .rdata_o(rdata), .err_o(err), .led_o(led)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // watchdog allows ten cycles per access which is far more than one handshake needs
   initial begin
      #((MAX_ACCESSES * 10 + 20) * CLK_PERIOD);
      $display("watchdog expired at %0t, the run did not finish", $time);
      $display("RESULT: FAIL");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int start_errors);
      tests++;
      $display("%-16s %s, %0d errors", name, (errors == start_errors) ? "ok" : "failed",
               errors - start_errors);
   endtask

   function automatic int size_bytes(input mem_bus_pkg::size_e s);
      case (s)
         mem_bus_pkg::SIZE_BYTE: return 1;
         mem_bus_pkg::SIZE_HALF: return 2;
         default:                return 4;
      endcase
   endfunction

   // one byte of the address map as the host should see it
   function automatic logic [7:0] model_byte(input int ba);
      mem_bus_pkg::word_t reg_word;
      if (ba < MEM_BYTES) return mem_model[ba];
      case ((ba >> 2) % 4)
         0:       reg_word = scratch_model;
         1:       reg_word = {24'h0, led_model};
         default: reg_word = mem_bus_pkg::ID_VALUE;
      endcase
      return reg_word[8 * (ba % 4) +: 8];
   endfunction

   // little endian so byte i of the data goes to address + i
   function automatic void model_write(input mem_bus_pkg::addr_t a, input mem_bus_pkg::size_e s,
                                       input mem_bus_pkg::word_t d);
      int ba;
      for (int i = 0; i < size_bytes(s); i++) begin
         ba = int'(a) + i;
         if (ba < MEM_BYTES) mem_model[ba] = d[8 * i +: 8];
         else if ((ba >> 2) % 4 == 0) scratch_model[8 * (ba % 4) +: 8] = d[8 * i +: 8];
         else if ((ba >> 2) % 4 == 1 && ba % 4 == 0) led_model = d[8 * i +: 8];  // low lane only
      end
   endfunction

   function automatic mem_bus_pkg::word_t model_read(input mem_bus_pkg::addr_t a,
                                                     input mem_bus_pkg::size_e s,
                                                     input logic sx);
      mem_bus_pkg::word_t v;
      v = '0;
      for (int i = 0; i < size_bytes(s); i++) v[8 * i +: 8] = model_byte(int'(a) + i);
      if (s == mem_bus_pkg::SIZE_BYTE && sx && v[7])  v[31:8]  = '1;
      if (s == mem_bus_pkg::SIZE_HALF && sx && v[15]) v[31:16] = '1;
      return v;
   endfunction

   // full four-phase access that starts and ends a little after an edge with ack low
   task automatic bus_access(input logic is_write, input mem_bus_pkg::size_e acc_size,
                             input logic sign_ext, input mem_bus_pkg::addr_t acc_addr,
                             input mem_bus_pkg::word_t acc_data,
                             output mem_bus_pkg::word_t got_data, output logic got_err);
      int waited;
      int hold;
      waited = 0;
      hold   = int'($urandom_range(0, 2));  // extra cycles with req held high
      req     = 1'b1;
      we      = is_write;
      size    = acc_size;
      sign_ld = sign_ext;
      addr    = acc_addr;
      wdata   = acc_data;
      @(posedge clk);                       // req first sampled here
      do begin
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end while (ack !== 1'b1 && waited < ACK_TIMEOUT);
      assert (ack === 1'b1) else begin
         $display("access to %h got no ack within %0d cycles", acc_addr, ACK_TIMEOUT);
         errors++;
      end
      check_value("ack_o rise latency", 32'(waited), 32'd2);
      got_data = rdata;
      got_err  = err;
      repeat (hold) begin
         @(posedge clk);
         #DRIVE_DLY;
         check_value("ack_o held", 32'(ack), 32'd1);
         check_value("rdata_o held", rdata, got_data);
         check_value("err_o held", 32'(err), 32'(got_err));
      end
      req    = 1'b0;
      waited = 0;
      do begin
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
      end while (ack !== 1'b0 && waited < ACK_TIMEOUT);
      check_value("ack_o fall latency", 32'(waited), 32'd1);
   endtask

   // access that must succeed with its result compared against the model
   task automatic good_access(input logic is_write, input mem_bus_pkg::size_e acc_size,
                              input logic sign_ext, input mem_bus_pkg::addr_t acc_addr,
                              input mem_bus_pkg::word_t acc_data);
      mem_bus_pkg::word_t rd;
      mem_bus_pkg::word_t exp;
      logic               e;
      exp = is_write ? '0 : model_read(acc_addr, acc_size, sign_ext);  // stores return zero
      bus_access(is_write, acc_size, sign_ext, acc_addr, acc_data, rd, e);
      if (is_write) model_write(acc_addr, acc_size, acc_data);
      check_value($sformatf("err_o at %h", acc_addr), 32'(e), 32'd0);
      check_value($sformatf("rdata_o at %h", acc_addr), rd, exp);
   endtask

   // access that must fail without touching anything
   task automatic bad_access(input logic is_write, input mem_bus_pkg::size_e acc_size,
                             input mem_bus_pkg::addr_t acc_addr);
      mem_bus_pkg::word_t rd;
      logic               e;
      bus_access(is_write, acc_size, 1'b0, acc_addr, 32'hDEAD_BEEF, rd, e);
      check_value($sformatf("err_o at %h", acc_addr), 32'(e), 32'd1);
      check_value($sformatf("rdata_o at %h", acc_addr), rd, 32'h0);
   endtask

   task automatic word_traffic();
      mem_bus_pkg::addr_t addrs[$];
      mem_bus_pkg::addr_t a;
      int                 start;
      start = errors;
      for (int i = 0; i < N_WORDS; i++) begin
         a = 16'($urandom_range(0, MEM_WORDS - 1) * 4);
         good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, a, $urandom());
         addrs.push_back(a);
      end
      foreach (addrs[i]) good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, addrs[i], '0);
      report_test("word_traffic", start);
   endtask

   task automatic partial_stores();
      mem_bus_pkg::addr_t a;
      mem_bus_pkg::size_e sz;
      int                 ofs;
      int                 start;
      start = errors;
      for (int i = 0; i < N_PART; i++) begin
         a  = 16'($urandom_range(0, MEM_WORDS - 1) * 4);
         sz = ($urandom_range(0, 1) == 0) ? mem_bus_pkg::SIZE_BYTE : mem_bus_pkg::SIZE_HALF;
         ofs = (sz == mem_bus_pkg::SIZE_BYTE) ? int'($urandom_range(0, 3))
                                              : 2 * int'($urandom_range(0, 1));
         good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, a, $urandom());  // known background
         good_access(1'b1, sz, 1'b0, 16'(int'(a) + ofs), $urandom());
         good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, a, '0);          // merged word
      end
      report_test("partial_stores", start);
   endtask

   task automatic load_extension();
      mem_bus_pkg::addr_t a;
      mem_bus_pkg::word_t d;
      int                 start;
      start = errors;
      for (int i = 0; i < N_LOAD; i++) begin
         a = 16'($urandom_range(0, MEM_WORDS - 1) * 4);
         d = $urandom();
         d = (i % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7F7F_7F7F);  // all sign bits set or clear
         good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, a, d);
         for (int s = 0; s < 2; s++) begin
            for (int b = 0; b < 4; b++) begin
               good_access(1'b0, mem_bus_pkg::SIZE_BYTE, s == 1, 16'(int'(a) + b), '0);
            end
            good_access(1'b0, mem_bus_pkg::SIZE_HALF, s == 1, a, '0);
            good_access(1'b0, mem_bus_pkg::SIZE_HALF, s == 1, 16'(int'(a) + 2), '0);
         end
      end
      report_test("load_extension", start);
   endtask

   task automatic io_registers();
      mem_bus_pkg::word_t c1;
      mem_bus_pkg::word_t c2;
      logic               e;
      int                 start;
      start = errors;
      // reset values first
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8000, '0);
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8004, '0);
      // scratch under byte and half enables
      for (int b = 0; b < 4; b++) begin
         good_access(1'b1, mem_bus_pkg::SIZE_BYTE, 1'b0, 16'(16'h8000 + b), $urandom());
         good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8000, '0);
      end
      good_access(1'b1, mem_bus_pkg::SIZE_HALF, 1'b0, 16'h8002, $urandom());
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8000, '0);
      // led register
      good_access(1'b1, mem_bus_pkg::SIZE_BYTE, 1'b0, 16'h8004, $urandom());
      check_value("led_o", 32'(led), 32'(led_model));
      good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8004, 32'hA5A5_A55A);
      check_value("led_o", 32'(led), 32'(led_model));
      good_access(1'b1, mem_bus_pkg::SIZE_BYTE, 1'b0, 16'h8005, 32'h0000_00FF);  // upper lane dropped
      check_value("led_o", 32'(led), 32'(led_model));
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8004, '0);
      // id word ignores writes
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h800C, '0);
      good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h800C, 32'h0000_0000);
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h800C, '0);
      // cycle counter
      bus_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8008, '0, c1, e);
      check_value("err_o at 8008", 32'(e), 32'd0);
      bus_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8008, '0, c2, e);
      check_value("err_o at 8008", 32'(e), 32'd0);
      checks++;
      assert (c2 > c1) else begin
         $display("cycle counter did not increase, read %h then %h", c1, c2);
         errors++;
      end
      report_test("io_registers", start);
   endtask

   task automatic error_accesses();
      int start;
      start = errors;
      good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h0000, 32'h0BAD_F00D);
      good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h0100, 32'hA5C3_5A3C);
      good_access(1'b1, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8000, 32'h1234_5678);
      // misaligned
      bad_access(1'b1, mem_bus_pkg::SIZE_HALF, 16'h0101);
      bad_access(1'b1, mem_bus_pkg::SIZE_HALF, 16'h0103);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h0101);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h0102);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h0103);
      bad_access(1'b0, mem_bus_pkg::SIZE_HALF, 16'h0101);
      bad_access(1'b0, mem_bus_pkg::SIZE_WORD, 16'h0102);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h8001);
      bad_access(1'b1, mem_bus_pkg::SIZE_HALF, 16'h8005);
      // unmapped where 0x2000 and 0x8010 would alias onto word 0 and scratch
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h2000);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h4000);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h7FFC);
      bad_access(1'b1, mem_bus_pkg::SIZE_WORD, 16'h8010);
      bad_access(1'b1, mem_bus_pkg::SIZE_BYTE, 16'hFFF0);
      bad_access(1'b0, mem_bus_pkg::SIZE_WORD, 16'h2000);
      bad_access(1'b0, mem_bus_pkg::SIZE_BYTE, 16'h8010);
      bad_access(1'b0, mem_bus_pkg::SIZE_WORD, 16'hC000);
      // nothing moved
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h0000, '0);
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h0100, '0);
      good_access(1'b0, mem_bus_pkg::SIZE_WORD, 1'b0, 16'h8000, '0);
      check_value("led_o", 32'(led), 32'(led_model));
      report_test("error_accesses", start);
   endtask

   initial begin
      void'($urandom(32'hea36_376f));
      tests         = 0;
      checks        = 0;
      errors        = 0;
      scratch_model = '0;
      led_model     = 8'h00;
      reset         = 1'b1;
      req           = 1'b0;
      we            = 1'b0;
      size          = mem_bus_pkg::SIZE_WORD;
      sign_ld       = 1'b0;
      addr          = '0;
      wdata         = '0;
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;
      check_value("ack_o after reset", 32'(ack), 32'd0);
      check_value("led_o after reset", 32'(led), 32'd0);
      word_traffic();
      partial_stores();
      load_extension();
      io_registers();
      error_accesses();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
hw/mem_bus_pkg.sv
hw/bus_req_ctrl.sv
hw/lane_align.sv
hw/addr_decode.sv
hw/data_mem.sv
hw/io_regs.sv
hw/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_mem_subsystem \
		-f sources.f -Mdir obj_dir -o tb_mem_subsystem
	./obj_dir/tb_mem_subsystem | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
